/* dmem_wb_master.sv */
`timescale 1ns/10ps

module dmem_wb_master
import lsq_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  dreq_t   dreq,
    output wb_m2s_t wb_o,
    input  wb_s2m_t wb_i,
    output word_t   data_in,
    output logic    data_valid
);

    typedef enum logic {
        idle,
        busy
    } bus_state_t;

    bus_state_t state;
    dreq_t      req_q;
    logic       req_present;

    assign req_present = (|dreq.rmask) || (|dreq.wmask);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (req_present) state <= busy;
                busy:    if (wb_i.ack) state <= idle;  // cyc drops the cycle after ack
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && req_present) begin
            req_q <= dreq;  // bus fields stay put while busy
        end
    end

    always_comb begin
        wb_o.cyc = (state == busy);
        wb_o.stb = (state == busy);
        wb_o.we  = |req_q.wmask;
        wb_o.adr = req_q.addr;
        wb_o.sel = (|req_q.wmask) ? req_q.wmask : req_q.rmask;
        wb_o.dat = req_q.wdata;
    end

    assign data_in    = wb_i.dat;
    assign data_valid = (state == busy) && wb_i.ack;

    // the queue must hold its head request for the whole bus cycle
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (state == busy) |-> (dreq == req_q));

endmodule

/* lsq_pkg.sv */
package lsq_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  rob_idx_t;
    typedef logic [5:0]  preg_t;
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  lsq_idx_t;   // caps the queue at 64 slots
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam opcode_t op_b_load  = 7'b0000011;
    localparam opcode_t op_b_store = 7'b0100011;

    localparam funct3_t load_f3_lb  = 3'b000;
    localparam funct3_t load_f3_lh  = 3'b001;
    localparam funct3_t load_f3_lw  = 3'b010;
    localparam funct3_t load_f3_lbu = 3'b100;
    localparam funct3_t load_f3_lhu = 3'b101;

    localparam funct3_t store_f3_sb = 3'b000;
    localparam funct3_t store_f3_sh = 3'b001;
    localparam funct3_t store_f3_sw = 3'b010;

    typedef struct packed {
        logic     valid;
        word_t    inst;
        opcode_t  opcode;
        funct3_t  funct3;
        preg_t    pd;
        rob_idx_t rob;
        areg_t    rd;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        lsq_idx_t idx;
        word_t    rs1_rdata;
        word_t    rs2_rdata;
        word_t    imm;
    } agu_req_t;

    typedef struct packed {
        logic     valid;
        lsq_idx_t idx;
        word_t    addr;
        word_t    store_wdata;
        word_t    rs1_rdata;
        word_t    rs2_rdata;
    } agu_res_t;

    typedef struct packed {
        logic       valid;
        logic       addr_ready;
        word_t      inst;
        opcode_t    opcode;
        funct3_t    funct3;
        preg_t      pd;
        rob_idx_t   rob;
        areg_t      rd;
        word_t      addr;
        logic [1:0] shift_bits;  // byte offset inside the word
        word_t      store_wdata;
        word_t      rs1_rdata;
        word_t      rs2_rdata;
        logic [3:0] rmask;
        logic [3:0] wmask;
        word_t      wdata;       // store data moved to its byte lanes
    } lsq_entry_t;

    typedef struct packed {
        word_t      addr;
        logic [3:0] rmask;
        logic [3:0] wmask;
        word_t      wdata;
    } dreq_t;

    typedef struct packed {
        logic       valid;
        rob_idx_t   rob_idx;
        preg_t      pd_s;
        areg_t      rd_s;
        word_t      rd_v;
        word_t      inst;
        word_t      addr;
        logic [3:0] rmask;
        logic [3:0] wmask;
        word_t      rdata;
        word_t      wdata;
        word_t      rs1_rdata;
        word_t      rs2_rdata;
    } cdb_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        logic [3:0] sel;
        word_t      dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

endpackage

/* lsu.f */
lsq_pkg.sv
mem_agu.sv
memory_queue.sv
dmem_wb_master.sv
wb_data_ram.sv
lsu_top.sv
tb_lsu_top.sv

/* lsu_top.sv */
`timescale 1ns/10ps

module lsu_top
import lsq_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16,
    parameter int MEM_WORDS   = 256
) (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t dispatch,
    input  agu_req_t  agu_req,
    input  rob_idx_t  commited_rob,
    output logic      full,
    output lsq_idx_t  mem_idx_out,
    output cdb_t      cdb_mem
);

    agu_res_t agu_res;
    dreq_t    dreq;
    word_t    data_in;
    logic     data_valid;
    wb_m2s_t  wb_m2s;
    wb_s2m_t  wb_s2m;

    mem_agu #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_agu (
        .clk (clk),
        .rst (rst),
        .req (agu_req),
        .res (agu_res)
    );

    memory_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .agu          (agu_res),
        .commited_rob (commited_rob),
        .data_in      (data_in),
        .data_valid   (data_valid),
        .full         (full),
        .mem_idx_out  (mem_idx_out),
        .dreq         (dreq),
        .cdb_mem      (cdb_mem)
    );

    dmem_wb_master u_master (
        .clk        (clk),
        .rst        (rst),
        .dreq       (dreq),
        .wb_o       (wb_m2s),
        .wb_i       (wb_s2m),
        .data_in    (data_in),
        .data_valid (data_valid)
    );

    wb_data_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) u_ram (
        .clk  (clk),
        .rst  (rst),
        .wb_i (wb_m2s),
        .wb_o (wb_s2m)
    );

endmodule

/* mem_agu.sv */
`timescale 1ns/10ps

module mem_agu
import lsq_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic     clk,
    input  logic     rst,
    input  agu_req_t req,
    output agu_res_t res
);

    word_t eff_addr;

    assign eff_addr = req.rs1_rdata + req.imm;  // base plus sign-extended imm

    always_ff @(posedge clk) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= req.valid;
        end
        if (req.valid) begin
            res.idx         <= req.idx;
            res.addr        <= eff_addr;
            res.store_wdata <= req.rs2_rdata;
            res.rs1_rdata   <= req.rs1_rdata;
            res.rs2_rdata   <= req.rs2_rdata;
        end
    end

    // the slot index comes from dispatch and must name a real queue entry
    a_idx_in_range: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> (req.idx < QUEUE_DEPTH));

endmodule

/* memory_queue.sv */
`timescale 1ns/10ps

module memory_queue
import lsq_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16  // power of two
) (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t dispatch,
    input  agu_res_t  agu,
    input  rob_idx_t  commited_rob,
    input  word_t     data_in,
    input  logic      data_valid,
    output logic      full,
    output lsq_idx_t  mem_idx_out,
    output dreq_t     dreq,
    output cdb_t      cdb_mem
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    lsq_entry_t     slots [QUEUE_DEPTH];
    logic [PTR_W:0] head;   // msb is the wrap bit
    logic [PTR_W:0] tail;
    lsq_entry_t     head_e;
    lsq_entry_t     agu_e;
    lsq_entry_t     enq_e;
    logic           enq;
    logic           head_is_load;
    logic           agu_is_load;
    logic [3:0]     agu_mask;
    logic [7:0]     ld_byte;
    logic [15:0]    ld_half;

    function automatic logic [3:0] size_mask(logic is_load, funct3_t f3, logic [1:0] off);
        logic [3:0] m;
        m = 4'b0000;
        if (is_load) begin
            case (f3)
                load_f3_lb, load_f3_lbu: m = 4'b0001 << off;
                load_f3_lh, load_f3_lhu: m = 4'b0011 << off;
                load_f3_lw:              m = 4'b1111;
                default:                 m = 4'b0000;
            endcase
        end else begin
            case (f3)
                store_f3_sb: m = 4'b0001 << off;
                store_f3_sh: m = 4'b0011 << off;
                store_f3_sw: m = 4'b1111;
                default:     m = 4'b0000;
            endcase
        end
        return m;
    endfunction

    function automatic word_t lane_wdata(funct3_t f3, logic [1:0] off, word_t d);
        word_t w;
        case (f3)
            store_f3_sb: w = {24'b0, d[7:0]} << {off, 3'b000};
            store_f3_sh: w = {16'b0, d[15:0]} << {off[1], 4'b0000};
            default:     w = d;
        endcase
        return w;
    endfunction

    assign head_e       = slots[head[PTR_W-1:0]];
    assign agu_e        = slots[agu.idx[PTR_W-1:0]];
    assign head_is_load = (head_e.opcode == op_b_load);
    assign agu_is_load  = (agu_e.opcode == op_b_load);
    assign agu_mask     = size_mask(agu_is_load, agu_e.funct3, agu.addr[1:0]);

    assign full        = (head[PTR_W-1:0] == tail[PTR_W-1:0]) && (head[PTR_W] != tail[PTR_W]);
    assign enq         = dispatch.valid && (!full || data_valid);  // dequeue frees a slot
    assign mem_idx_out = lsq_idx_t'(tail[PTR_W-1:0]);

    always_comb begin
        enq_e        = '0;
        enq_e.valid  = 1'b1;
        enq_e.inst   = dispatch.inst;
        enq_e.opcode = dispatch.opcode;
        enq_e.funct3 = dispatch.funct3;
        enq_e.pd     = dispatch.pd;
        enq_e.rob    = dispatch.rob;
        enq_e.rd     = dispatch.rd;
    end

    // head request, stores wait for their commit
    always_comb begin
        dreq = '0;
        if (head_e.valid && head_e.addr_ready &&
            (head_is_load || head_e.rob == commited_rob)) begin
            dreq.addr  = {head_e.addr[31:2], 2'b00};
            dreq.rmask = head_e.rmask;
            dreq.wmask = head_e.wmask;
            dreq.wdata = head_e.wdata;
        end
    end

    assign ld_byte = data_in[{head_e.shift_bits, 3'b000} +: 8];
    assign ld_half = data_in[{head_e.shift_bits[1], 4'b0000} +: 16];

    always_comb begin
        cdb_mem = '0;
        if (data_valid) begin
            cdb_mem.valid     = 1'b1;
            cdb_mem.rob_idx   = head_e.rob;
            cdb_mem.pd_s      = head_e.pd;
            cdb_mem.inst      = head_e.inst;
            cdb_mem.addr      = head_e.addr;
            cdb_mem.rmask     = head_e.rmask;
            cdb_mem.wmask     = head_e.wmask;
            cdb_mem.rs1_rdata = head_e.rs1_rdata;
            cdb_mem.rs2_rdata = head_e.rs2_rdata;
            if (head_is_load) begin
                cdb_mem.rd_s  = head_e.rd;
                cdb_mem.rdata = data_in;
                case (head_e.funct3)
                    load_f3_lb:  cdb_mem.rd_v = {{24{ld_byte[7]}}, ld_byte};
                    load_f3_lbu: cdb_mem.rd_v = {24'b0, ld_byte};
                    load_f3_lh:  cdb_mem.rd_v = {{16{ld_half[15]}}, ld_half};
                    load_f3_lhu: cdb_mem.rd_v = {16'b0, ld_half};
                    default:     cdb_mem.rd_v = data_in;
                endcase
            end else begin
                cdb_mem.wdata = head_e.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                slots[i].valid      <= 1'b0;
                slots[i].addr_ready <= 1'b0;
            end
        end else begin
            if (agu.valid) begin
                slots[agu.idx[PTR_W-1:0]].addr_ready  <= 1'b1;
                slots[agu.idx[PTR_W-1:0]].addr        <= agu.addr;
                slots[agu.idx[PTR_W-1:0]].shift_bits  <= agu.addr[1:0];
                slots[agu.idx[PTR_W-1:0]].store_wdata <= agu.store_wdata;
                slots[agu.idx[PTR_W-1:0]].rs1_rdata   <= agu.rs1_rdata;
                slots[agu.idx[PTR_W-1:0]].rs2_rdata   <= agu.rs2_rdata;
                slots[agu.idx[PTR_W-1:0]].rmask       <= agu_is_load ? agu_mask : 4'b0000;
                slots[agu.idx[PTR_W-1:0]].wmask       <= agu_is_load ? 4'b0000 : agu_mask;
                slots[agu.idx[PTR_W-1:0]].wdata       <= agu_is_load ? '0 :
                    lane_wdata(agu_e.funct3, agu.addr[1:0], agu.store_wdata);
            end
            if (data_valid) begin
                slots[head[PTR_W-1:0]].valid <= 1'b0;
                head <= head + 1'b1;
            end
            // after the dequeue clear, so a full-queue enqueue keeps its slot
            if (enq) begin
                slots[tail[PTR_W-1:0]] <= enq_e;
                tail <= tail + 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (dispatch.valid && full) |-> data_valid);

    a_dv_needs_req: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> ((|dreq.rmask) || (|dreq.wmask)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu_top -f lsu.f
./obj_dir/Vtb_lsu_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log

/* tb_lsu_top.sv */
`timescale 1ns/10ps

module tb_lsu_top
import lsq_pkg::*;
();

    localparam int QUEUE_DEPTH = 16;
    localparam int MEM_WORDS   = 256;
    localparam int NUM_RANDOM  = 300;

    typedef struct packed {
        word_t    inst;
        opcode_t  opcode;
        funct3_t  f3;
        preg_t    pd;
        rob_idx_t rob;
        areg_t    rd;
        lsq_idx_t slot;
        word_t    addr;
        word_t    rs1;
        word_t    rs2;
        word_t    imm;
        logic     has_addr;
    } model_entry_t;

    logic      clk;
    logic      rst;
    dispatch_t dispatch;
    agu_req_t  agu_req;
    rob_idx_t  commited_rob;
    logic      full;
    lsq_idx_t  mem_idx_out;
    cdb_t      cdb_mem;

    model_entry_t model_q[$];   // outstanding entries, oldest first
    word_t        mem_model [MEM_WORDS];
    word_t        rng_state = 32'h23cd;
    rob_idx_t     next_rob;
    int           done_cnt;
    int           issued;
    logic         hold_addr;
    logic         hold_commit;

    lsu_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .MEM_WORDS  (MEM_WORDS)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .agu_req      (agu_req),
        .commited_rob (commited_rob),
        .full         (full),
        .mem_idx_out  (mem_idx_out),
        .cdb_mem      (cdb_mem)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic stop_with_error(string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(string what, word_t got, word_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    // access size from funct3, moved to the byte offset
    function automatic logic [3:0] lane_mask(funct3_t f3, logic [1:0] off);
        case (f3[1:0])
            2'b00:   return 4'b0001 << off;
            2'b01:   return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic retire_head();
        model_entry_t e;
        word_t        word;
        word_t        shifted;
        word_t        exp_v;
        word_t        exp_wd;
        logic [3:0]   mask;
        int           wi;
        if (model_q.size() == 0) begin
            stop_with_error("cdb output arrived with no entry outstanding");
        end
        e = model_q.pop_front();
        wi = int'(e.addr >> 2);
        word = mem_model[wi];
        shifted = word >> (8 * e.addr[1:0]);
        mask = lane_mask(e.f3, e.addr[1:0]);
        check("cdb rob_idx", cdb_mem.rob_idx, e.rob);
        check("cdb pd_s", cdb_mem.pd_s, e.pd);
        check("cdb inst", cdb_mem.inst, e.inst);
        check("cdb addr", cdb_mem.addr, e.addr);
        check("cdb rs1_rdata", cdb_mem.rs1_rdata, e.rs1);
        check("cdb rs2_rdata", cdb_mem.rs2_rdata, e.rs2);
        if (e.opcode == op_b_load) begin
            case (e.f3)
                load_f3_lb:  exp_v = {{24{shifted[7]}}, shifted[7:0]};
                load_f3_lbu: exp_v = {24'b0, shifted[7:0]};
                load_f3_lh:  exp_v = {{16{shifted[15]}}, shifted[15:0]};
                load_f3_lhu: exp_v = {16'b0, shifted[15:0]};
                default:     exp_v = word;
            endcase
            check("load rd_v", cdb_mem.rd_v, exp_v);
            check("load rd_s", cdb_mem.rd_s, e.rd);
            check("load rdata", cdb_mem.rdata, word);
            check("load rmask", cdb_mem.rmask, mask);
            check("load wmask", cdb_mem.wmask, 0);
            check("load wdata", cdb_mem.wdata, 0);
        end else begin
            case (e.f3)
                store_f3_sb: exp_wd = {24'b0, e.rs2[7:0]} << (8 * e.addr[1:0]);
                store_f3_sh: exp_wd = {16'b0, e.rs2[15:0]} << (8 * e.addr[1:0]);
                default:     exp_wd = e.rs2;
            endcase
            check("store wmask", cdb_mem.wmask, mask);
            check("store wdata", cdb_mem.wdata, exp_wd);
            check("store rmask", cdb_mem.rmask, 0);
            check("store rdata", cdb_mem.rdata, 0);
            check("store rd_s", cdb_mem.rd_s, 0);
            check("store rd_v", cdb_mem.rd_v, 0);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) mem_model[wi][8*b +: 8] = exp_wd[8*b +: 8];
            end
        end
        done_cnt++;
    endtask

    // one clock: commit, cdb check, then fresh inputs
    task automatic step();
        int    cand[$];
        int    pick;
        int    first_store;
        word_t r;
        @(negedge clk);
        first_store = -1;
        foreach (model_q[i]) begin
            if (first_store < 0 && model_q[i].opcode == op_b_store) first_store = i;
        end
        // taken before retiring, so a store on the bus keeps its commit
        if (first_store >= 0) begin
            commited_rob = hold_commit ? rob_idx_t'(model_q[first_store].rob + 1)
                                       : model_q[first_store].rob;
        end
        if (cdb_mem.valid) retire_head();
        dispatch = '0;
        agu_req  = '0;
        if (!hold_addr) begin
            foreach (model_q[i]) begin
                if (!model_q[i].has_addr) cand.push_back(i);
            end
            r = xorshift32();
            if (cand.size() > 0 && r[0]) begin
                pick = cand[r[31:8] % cand.size()];   // any unaddressed entry
                agu_req.valid     = 1'b1;
                agu_req.idx       = model_q[pick].slot;
                agu_req.rs1_rdata = model_q[pick].rs1;
                agu_req.rs2_rdata = model_q[pick].rs2;
                agu_req.imm       = model_q[pick].imm;
                model_q[pick].has_addr = 1'b1;
            end
        end
    endtask

    task automatic dispatch_one(int kind);  // 0 random, 1 store, 2 load
        model_entry_t e;
        word_t        r;
        logic [1:0]   off;
        r = xorshift32();
        e.opcode = (kind == 1 || (kind == 0 && r[0])) ? op_b_store : op_b_load;
        if (e.opcode == op_b_load) begin
            case (r[7:4] % 5)
                0:       e.f3 = load_f3_lb;
                1:       e.f3 = load_f3_lbu;
                2:       e.f3 = load_f3_lh;
                3:       e.f3 = load_f3_lhu;
                default: e.f3 = load_f3_lw;
            endcase
        end else begin
            case (r[7:4] % 3)
                0:       e.f3 = store_f3_sb;
                1:       e.f3 = store_f3_sh;
                default: e.f3 = store_f3_sw;
            endcase
        end
        case (e.f3[1:0])
            2'b00:   off = r[9:8];
            2'b01:   off = {r[8], 1'b0};
            default: off = 2'b00;
        endcase
        e.addr = {26'b0, r[15:12], off};  // 16 words, so loads hit earlier stores
        r = xorshift32();
        e.imm      = {{20{r[11]}}, r[11:0]};
        e.rs1      = e.addr - e.imm;
        e.rs2      = xorshift32();
        e.inst     = xorshift32();
        r = xorshift32();
        e.pd       = r[5:0];
        e.rd       = r[10:6];
        e.rob      = next_rob;
        e.slot     = mem_idx_out;
        e.has_addr = 1'b0;
        next_rob++;
        model_q.push_back(e);
        dispatch.valid  = 1'b1;
        dispatch.inst   = e.inst;
        dispatch.opcode = e.opcode;
        dispatch.funct3 = e.f3;
        dispatch.pd     = e.pd;
        dispatch.rob    = e.rob;
        dispatch.rd     = e.rd;
        issued++;
    endtask

    task automatic drain(int limit, string what);
        int n;
        n = 0;
        while (model_q.size() != 0) begin
            if (n == limit) begin
                stop_with_error($sformatf("timeout in %s: %0d entries never left the queue",
                    what, model_q.size()));
            end
            step();
            n++;
        end
    endtask

    initial begin
        word_t r;
        int    n;
        int    base;
        rst          = 1'b1;
        dispatch     = '0;
        agu_req      = '0;
        commited_rob = '0;
        next_rob     = '0;
        done_cnt     = 0;
        issued       = 0;
        hold_addr    = 1'b0;
        hold_commit  = 1'b0;
        foreach (mem_model[i]) mem_model[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("full after reset", full, 0);
        check("cdb valid after reset", cdb_mem.valid, 0);
        check("mem_idx_out after reset", mem_idx_out, 0);

        n = 0;
        while (issued < NUM_RANDOM) begin
            if (n == 20000) stop_with_error("timeout: random dispatch stalled on a full queue");
            step();
            r = xorshift32();
            if (!full && r[1:0] != 2'b00) dispatch_one(0);
            n++;
        end
        drain(2000, "random mix");

        // store held back by commit, younger load stuck behind it
        hold_commit = 1'b1;
        step();
        dispatch_one(1);
        step();
        dispatch_one(2);
        base = done_cnt;
        for (int c = 0; c < 60; c++) begin
            step();
            check("cdb outputs under held commit", done_cnt, base);
        end
        hold_commit = 1'b0;
        drain(200, "commit release");

        hold_addr = 1'b1;
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            step();
            check("full before depth reached", full, 0);
            dispatch_one(0);
        end
        step();
        check("full after depth enqueues", full, 1);
        hold_addr = 1'b0;
        drain(2000, "full queue");
        check("full after drain", full, 0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* wb_data_ram.sv */
`timescale 1ns/10ps

module wb_data_ram
import lsq_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            ram [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             hit;
    logic             ack_q;
    word_t            dat_q;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            ram[i] = '0;
        end
    end

    assign idx = wb_i.adr[IDX_W+1:2];
    assign hit = wb_i.cyc && wb_i.stb && !ack_q;  // one ack per strobe

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            dat_q <= ram[idx];
            if (wb_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_i.sel[b]) ram[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                end
            end
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = dat_q;

    // strobe only inside a bus cycle
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_i.stb |-> wb_i.cyc);

    // addresses above the array would alias
    a_adr_in_range: assert property (@(posedge clk) disable iff (rst)
        wb_i.stb |-> ((wb_i.adr >> (IDX_W + 2)) == 0));

endmodule
